//--- src.f
hdl/cgra_pkg.sv
hdl/cgra_conf_loader.sv
hdl/conf_word_decode.sv
hdl/pe_exec_array.sv
hdl/result_pack.sv
hdl/cgra_top.sv
bench/conf_mem_model.sv
bench/tb_cgra_top.sv

//--- Bender.yml
package:
  name: cgra_conf

sources:
  - hdl/cgra_pkg.sv
  - hdl/cgra_conf_loader.sv
  - hdl/conf_word_decode.sv
  - hdl/pe_exec_array.sv
  - hdl/result_pack.sv
  - hdl/cgra_top.sv
  - target: simulation
    files:
      - bench/conf_mem_model.sv
      - bench/tb_cgra_top.sv

//--- bench/tb_cgra_top.sv
`timescale 1ns/1ns

module tb_cgra_top
  import cgra_pkg::*;
();

  logic              clk;
  logic              rst;
  logic              start;
  logic              available_read;
  logic              req_rd_data;
  logic [LINE_W-1:0] rd_data;
  logic              rd_data_valid;
  logic [31:0]       read_fifo_mask;
  logic [31:0]       write_fifo_mask;
  logic              done;
  logic [DATA_W-1:0] data_in;
  logic              data_in_valid;
  logic [OUT_W-1:0]  out_data;
  logic              out_valid;
  int                req_count;

  int                seed = 94203;
  int                error_count = 0;
  int                timeout_count = 0;
  int                recv_count = 0;
  logic [OUT_W-1:0]  exp_q[$];
  logic [OUT_W-1:0]  exp_word;
  conf_word_t        words[$];
  op_t               ref_op[NUM_PE];
  logic [DATA_W-1:0] ref_cst[NUM_PE];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  cgra_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .available_read  (available_read),
    .req_rd_data     (req_rd_data),
    .rd_data         (rd_data),
    .rd_data_valid   (rd_data_valid),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (done),
    .data_in         (data_in),
    .data_in_valid   (data_in_valid),
    .out_data        (out_data),
    .out_valid       (out_valid)
  );

  conf_mem_model u_mem (
    .clk            (clk),
    .rst            (rst),
    .req_rd_data    (req_rd_data),
    .available_read (available_read),
    .rd_data        (rd_data),
    .rd_data_valid  (rd_data_valid),
    .req_count      (req_count)
  );

  task automatic push_word(input logic vld, input int pe, input int field,
                           input logic [31:0] value);
    conf_word_t w;
    w       = '0;
    w.vld   = vld;
    w.pe_id = 8'(pe);
    w.field = 8'(field);
    w.value = value;
    words.push_back(w);
  endtask

  task automatic apply_ref_word(input conf_word_t w);
    if (w.vld && w.pe_id < NUM_PE) begin
      if (w.field == 8'd1) begin
        ref_cst[w.pe_id] = w.value;
      end else begin
        ref_op[w.pe_id] = op_t'(w.value[1:0]);
      end
    end
  endtask

  function automatic logic [DATA_W-1:0] ref_chain(input logic [DATA_W-1:0] x);
    logic [DATA_W-1:0] v;
    v = x;
    for (int p = 0; p < NUM_PE; p++) begin
      case (ref_op[p])
        OP_ADD:  v = v + ref_cst[p];
        OP_XOR:  v = v ^ ref_cst[p];
        OP_SUB:  v = v - ref_cst[p];
        default: v = v;
      endcase
    end
    return v;
  endfunction

  task automatic reset_dut();
    @(negedge clk);
    rst           = 1'b1;
    start         = 1'b0;
    data_in_valid = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    words.delete();
    exp_q.delete();
    for (int p = 0; p < NUM_PE; p++) begin
      ref_op[p]  = OP_PASS;
      ref_cst[p] = '0;
    end
  endtask

  // Header line followed by the queued words eight to a line
  task automatic run_config(input int qtd, input logic [31:0] rmask, input logic [31:0] wmask);
    conf_hdr_t         hdr;
    logic [LINE_W-1:0] line;
    int                cycles;
    int                exp_reqs;
    hdr.qtd_conf   = qtd;
    hdr.read_mask  = rmask;
    hdr.write_mask = wmask;
    line           = '0;
    line[$bits(conf_hdr_t)-1:0] = hdr;
    u_mem.clear_lines();
    u_mem.write_line(0, line);
    for (int i = 0; i < words.size(); i++) begin
      if (i % WORDS_PER_LINE == 0) begin
        line = '0;
      end
      line[(i % WORDS_PER_LINE)*CONF_W +: CONF_W] = words[i];
      u_mem.write_line(1 + i / WORDS_PER_LINE, line);
    end
    for (int i = 0; i < qtd; i++) begin
      apply_ref_word(words[i]);    // Words past qtd_conf never reach a PE
    end
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;
    while (!done && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      timeout_count++;
      $display("Loader never raised done with qtd_conf %0d", qtd);
    end else begin
      exp_reqs = 1 + (qtd + WORDS_PER_LINE - 1) / WORDS_PER_LINE;
      assert (read_fifo_mask == rmask && write_fifo_mask == wmask) else begin
        error_count++;
        $display("[ERROR] %0t: masks %h/%h, expected %h/%h", $time,
                 read_fifo_mask, write_fifo_mask, rmask, wmask);
      end
      assert (req_count == exp_reqs) else begin
        error_count++;
        $display("[ERROR] %0t: %0d line requests, expected %0d", $time, req_count, exp_reqs);
      end
      repeat (CONF_DRAIN_CYCLES) @(negedge clk);
      assert (done) else begin
        error_count++;
        $display("[ERROR] %0t: done dropped after rising", $time);
      end
    end
  endtask

  task automatic stream_pairs(input int n_pairs);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    int                cycles;
    recv_count = 0;
    for (int k = 0; k < n_pairs; k++) begin
      a = $random(seed);
      b = $random(seed);
      exp_q.push_back({ref_chain(b), ref_chain(a)});
      @(negedge clk);
      data_in       = a;
      data_in_valid = 1'b1;
      @(negedge clk);
      data_in = b;
    end
    @(negedge clk);
    data_in_valid = 1'b0;
    cycles        = 0;
    while (recv_count < n_pairs && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (recv_count < n_pairs) begin
      timeout_count++;
      $display("Only %0d of %0d packed words came out", recv_count, n_pairs);
    end
  endtask

  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Packed word %h came out with no input pair outstanding", out_data);
      end else begin
        exp_word = exp_q.pop_front();
        assert (out_data == exp_word) else begin
          error_count++;
          $display("[ERROR] %0t: out_data %h, expected %h", $time, out_data, exp_word);
        end
        recv_count++;
      end
    end
  end

  task automatic test_no_config();
    reset_dut();
    assert (!done && read_fifo_mask == '0 && write_fifo_mask == '0) else begin
      error_count++;
      $display("[ERROR] %0t: done or masks not clear after reset", $time);
    end
    stream_pairs(6);
  endtask

  task automatic test_pe_ops();
    reset_dut();
    push_word(1'b1, 0, 0, OP_ADD);
    push_word(1'b1, 0, 1, 32'h1000_0001);
    push_word(1'b1, 1, 0, OP_XOR);
    push_word(1'b1, 1, 1, 32'hA5A5_5A5A);
    push_word(1'b1, 2, 0, OP_SUB);
    push_word(1'b1, 2, 1, 32'h0000_0077);
    push_word(1'b1, 3, 0, OP_PASS);
    push_word(1'b1, 3, 1, 32'hDEAD_BEEF);
    run_config(8, 32'h0000_00F3, 32'h0000_0C01);
    stream_pairs(8);
  endtask

  task automatic test_ignored_words();
    reset_dut();
    push_word(1'b1, 0, 0, OP_ADD);
    push_word(1'b1, 0, 1, 32'd5);
    push_word(1'b0, 0, 0, OP_XOR);        // vld clear
    push_word(1'b0, 0, 1, 32'h0000_FFFF);
    push_word(1'b1, 4, 0, OP_SUB);        // Aliases PE0 without the range check
    push_word(1'b1, 9, 1, 32'h0000_1234);
    push_word(1'b1, 200, 0, OP_XOR);
    push_word(1'b1, 1, 0, OP_XOR);
    push_word(1'b1, 1, 1, 32'h0F0F_0F0F);
    push_word(1'b1, 2, 0, OP_SUB);
    push_word(1'b1, 2, 1, 32'h0000_0010);
    run_config(11, 32'h1234_5678, 32'h8765_4321);
    stream_pairs(6);
  endtask

  task automatic test_extra_words();
    reset_dut();
    push_word(1'b1, 0, 0, OP_ADD);
    push_word(1'b1, 0, 1, 32'h0000_0100);
    push_word(1'b1, 1, 0, OP_SUB);
    push_word(1'b1, 1, 1, 32'd3);
    push_word(1'b1, 2, 1, 32'd7);          // PE2 stays on OP_PASS
    push_word(1'b1, 2, 0, OP_ADD);         // Rest of the line lies past qtd_conf
    push_word(1'b1, 1, 0, OP_XOR);
    push_word(1'b1, 0, 1, 32'hFFFF_0000);
    run_config(5, 32'h0000_0001, 32'h8000_0000);
    stream_pairs(6);
  endtask

  initial begin
    rst           = 1'b1;
    start         = 1'b0;
    data_in       = '0;
    data_in_valid = 1'b0;
    test_no_config();
    test_pe_ops();
    test_ignored_words();
    test_extra_words();
    $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- bench/conf_mem_model.sv
`timescale 1ns/1ns

module conf_mem_model
  import cgra_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req_rd_data,
  output logic              available_read,
  output logic [LINE_W-1:0] rd_data,
  output logic              rd_data_valid,
  output int                req_count
);

  logic [LINE_W-1:0] mem[int];
  int                seed = 94203;
  int                rd_ptr;
  int                delay;
  logic              pending;

  initial begin
    available_read = 1'b0;
    rd_data        = '0;
    rd_data_valid  = 1'b0;
    req_count      = 0;
  end

  task automatic write_line(input int idx, input logic [LINE_W-1:0] line);
    mem[idx] = line;
  endtask

  task automatic clear_lines();
    mem.delete();
  endtask

  // Outputs change on the falling edge, the loader samples on the rising one
  always @(negedge clk) begin
    if (rst) begin
      available_read = 1'b0;
      rd_data_valid  = 1'b0;
      req_count      = 0;
      rd_ptr         = 0;
      pending        = 1'b0;
    end else begin
      rd_data_valid = 1'b0;
      if (pending && delay == 0) begin
        rd_data       = mem.exists(rd_ptr) ? mem[rd_ptr] : '0;  // Past the image reads as idle
        rd_data_valid = 1'b1;
        rd_ptr++;
        pending = 1'b0;
      end else if (pending) begin
        delay--;
      end
      if (req_rd_data) begin
        req_count++;
        pending = 1'b1;
        delay   = $unsigned($random(seed)) % 4;
      end
      available_read = ($unsigned($random(seed)) % 4) != 0;  // Low about one cycle in four
    end
  end

endmodule

//--- hdl/cgra_top.sv
`timescale 1ns/1ns

module cgra_top
  import cgra_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              available_read,
  output logic              req_rd_data,
  input  logic [LINE_W-1:0] rd_data,
  input  logic              rd_data_valid,
  output logic [31:0]       read_fifo_mask,
  output logic [31:0]       write_fifo_mask,
  output logic              done,
  input  logic [DATA_W-1:0] data_in,
  input  logic              data_in_valid,
  output logic [OUT_W-1:0]  out_data,
  output logic              out_valid
);

  conf_word_t        conf_bus;
  pe_wr_t            pe_wr;
  logic [DATA_W-1:0] res_data;
  logic              res_valid;

  cgra_conf_loader u_loader (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .available_read  (available_read),
    .req_rd_data     (req_rd_data),
    .rd_data         (rd_data),
    .rd_data_valid   (rd_data_valid),
    .conf_out_bus    (conf_bus),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (done)
  );

  conf_word_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .conf_in (conf_bus),
    .pe_wr   (pe_wr)
  );

  pe_exec_array u_exec (
    .clk           (clk),
    .rst           (rst),
    .pe_wr         (pe_wr),
    .data_in       (data_in),
    .data_in_valid (data_in_valid),
    .res_data      (res_data),
    .res_valid     (res_valid)
  );

  result_pack u_result (
    .clk       (clk),
    .rst       (rst),
    .res_data  (res_data),
    .res_valid (res_valid),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

endmodule

//--- hdl/result_pack.sv
`timescale 1ns/1ns

module result_pack
  import cgra_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] res_data,
  input  logic              res_valid,
  output logic [OUT_W-1:0]  out_data,
  output logic              out_valid
);

  logic              half;    // Low half already held
  logic [DATA_W-1:0] low_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      half      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (res_valid) begin
        half <= ~half;
        if (half) begin
          out_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      if (half) begin
        out_data <= {res_data, low_q};   // Second result on top
      end else begin
        low_q <= res_data;
      end
    end
  end

endmodule

//--- hdl/pe_exec_array.sv
`timescale 1ns/1ns

module pe_exec_array
  import cgra_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  pe_wr_t            pe_wr,
  input  logic [DATA_W-1:0] data_in,
  input  logic              data_in_valid,
  output logic [DATA_W-1:0] res_data,
  output logic              res_valid
);

  op_t               pe_op   [NUM_PE];
  logic [DATA_W-1:0] pe_cst  [NUM_PE];
  logic [DATA_W-1:0] stg_data[NUM_PE];
  logic              stg_vld [NUM_PE];

  function automatic logic [DATA_W-1:0] apply_op(
    input op_t               op,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] k
  );
    logic [DATA_W-1:0] r;
    case (op)
      OP_ADD:  r = a + k;
      OP_XOR:  r = a ^ k;
      OP_SUB:  r = a - k;
      default: r = a;
    endcase
    return r;
  endfunction

  // Per-PE configuration registers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_PE; i++) begin
        pe_op[i]  <= OP_PASS;
        pe_cst[i] <= '0;
      end
    end else if (pe_wr.en) begin
      if (pe_wr.is_const) begin
        pe_cst[pe_wr.pe_sel] <= pe_wr.value[DATA_W-1:0];
      end else begin
        pe_op[pe_wr.pe_sel] <= op_t'(pe_wr.value[1:0]);
      end
    end
  end

  // Valid bits of the chain
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_PE; i++) begin
        stg_vld[i] <= 1'b0;
      end
    end else begin
      stg_vld[0] <= data_in_valid;
      for (int i = 1; i < NUM_PE; i++) begin
        stg_vld[i] <= stg_vld[i-1];
      end
    end
  end

  // Data chain, stage i runs PE i
  always_ff @(posedge clk) begin
    stg_data[0] <= apply_op(pe_op[0], data_in, pe_cst[0]);
    for (int i = 1; i < NUM_PE; i++) begin
      stg_data[i] <= apply_op(pe_op[i], stg_data[i-1], pe_cst[i]);
    end
  end

  assign res_data  = stg_data[NUM_PE-1];
  assign res_valid = stg_vld[NUM_PE-1];

endmodule

//--- hdl/conf_word_decode.sv
`timescale 1ns/1ns

module conf_word_decode
  import cgra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  conf_word_t conf_in,
  output pe_wr_t     pe_wr
);

  logic   hit;
  pe_wr_t wr_d;

  // Real write aimed at an existing PE
  assign hit = conf_in.vld && (conf_in.pe_id < 8'(NUM_PE));

  always_comb begin
    wr_d          = '0;
    wr_d.en       = hit;
    wr_d.pe_sel   = conf_in.pe_id[PE_SEL_W-1:0];
    wr_d.is_const = (conf_in.field == 8'd1);
    wr_d.value    = conf_in.value;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pe_wr <= '0;
    end else begin
      pe_wr <= wr_d;
    end
  end

endmodule

//--- hdl/cgra_conf_loader.sv
`timescale 1ns/1ns

module cgra_conf_loader
  import cgra_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              available_read,
  output logic              req_rd_data,
  input  logic [LINE_W-1:0] rd_data,
  input  logic              rd_data_valid,
  output conf_word_t        conf_out_bus,
  output logic [31:0]       read_fifo_mask,
  output logic [31:0]       write_fifo_mask,
  output logic              done
);

  typedef enum logic [2:0] {
    st_idle,
    st_req,
    st_wait,
    st_init,
    st_send,
    st_drain,
    st_done
  } state_t;

  state_t                 state;
  state_t                 ret_state;   // Where to go once the line is in
  logic [LINE_W-1:0]      line_q;
  conf_hdr_t              hdr;
  logic [31:0]            qtd_conf;
  logic [31:0]            word_cnt;
  logic [LINE_CNT_W-1:0]  line_cnt;
  logic [DRAIN_CNT_W-1:0] drain_cnt;
  conf_word_t             conf_data;
  logic                   send_conf;
  logic                   take_line;
  logic                   take_word;

  assign hdr       = conf_hdr_t'(line_q[$bits(conf_hdr_t)-1:0]);
  assign take_line = (state == st_wait) && rd_data_valid;
  assign take_word = (state == st_send) && (word_cnt < qtd_conf) &&
                     (line_cnt < LINE_CNT_W'(WORDS_PER_LINE));

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= st_idle;
      ret_state       <= st_idle;
      req_rd_data     <= 1'b0;
      send_conf       <= 1'b0;
      qtd_conf        <= '0;
      word_cnt        <= '0;
      line_cnt        <= LINE_CNT_W'(WORDS_PER_LINE);  // Forces a fetch on first send
      drain_cnt       <= '0;
      read_fifo_mask  <= '0;
      write_fifo_mask <= '0;
      done            <= 1'b0;
    end else begin
      req_rd_data <= 1'b0;
      send_conf   <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_req;
            ret_state <= st_init;     // First line is the header
          end
        end
        st_req: begin
          if (available_read) begin
            req_rd_data <= 1'b1;
            state       <= st_wait;
          end
        end
        st_wait: begin
          if (rd_data_valid) begin
            state <= ret_state;
          end
        end
        st_init: begin
          qtd_conf        <= hdr.qtd_conf;
          read_fifo_mask  <= hdr.read_mask;
          write_fifo_mask <= hdr.write_mask;
          state           <= st_send;
        end
        st_send: begin
          if (word_cnt >= qtd_conf) begin
            state <= st_drain;
          end else if (take_word) begin
            send_conf <= 1'b1;
            word_cnt  <= word_cnt + 32'd1;
            line_cnt  <= line_cnt + 1'b1;
          end else begin
            // Current line used up
            line_cnt  <= '0;
            state     <= st_req;
            ret_state <= st_send;
          end
        end
        st_drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_CNT_W'(CONF_DRAIN_CYCLES - 1)) begin
            state <= st_done;
          end
        end
        st_done: begin
          done <= 1'b1;   // Held until reset
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_line) begin
      line_q <= rd_data;
    end else if (take_word) begin
      conf_data <= conf_word_t'(line_q[CONF_W-1:0]);
      line_q    <= line_q >> CONF_W;
    end
  end

  // Bus is zero except in the cycle after a send pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      conf_out_bus <= '0;
    end else if (send_conf) begin
      conf_out_bus <= conf_data;
    end else begin
      conf_out_bus <= '0;
    end
  end

endmodule

//--- hdl/cgra_pkg.sv
package cgra_pkg;

  localparam int LINE_W            = 512;
  localparam int CONF_W            = 64;
  localparam int WORDS_PER_LINE    = 8;
  localparam int NUM_PE            = 4;
  localparam int DATA_W            = 32;
  localparam int OUT_W             = 2 * DATA_W;
  localparam int CONF_DRAIN_CYCLES = 8;

  localparam int PE_SEL_W    = $clog2(NUM_PE);
  localparam int LINE_CNT_W  = $clog2(WORDS_PER_LINE + 1);
  localparam int DRAIN_CNT_W = $clog2(CONF_DRAIN_CYCLES + 1);

  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_ADD  = 2'd1,
    OP_XOR  = 2'd2,
    OP_SUB  = 2'd3
  } op_t;

  // One word on the configuration bus, vld is the top bit
  typedef struct packed {
    logic        vld;
    logic [6:0]  rsvd;
    logic [7:0]  pe_id;
    logic [7:0]  field;   // 0 opcode, 1 constant
    logic [7:0]  pad;
    logic [31:0] value;
  } conf_word_t;

  typedef struct packed {
    logic                en;
    logic [PE_SEL_W-1:0] pe_sel;
    logic                is_const;
    logic [31:0]         value;
  } pe_wr_t;

  // Low 96 bits of the header line, qtd_conf sits in bits 31:0
  typedef struct packed {
    logic [31:0] write_mask;
    logic [31:0] read_mask;
    logic [31:0] qtd_conf;
  } conf_hdr_t;

endpackage
